// File: hdl/conn_pkg.sv
package conn_pkg;

    // ----------------------------------------
    // Table geometry
    // ----------------------------------------

    // Associativity of each table row
    localparam int WAYS          = 4;
    localparam int WAYS_LOG      = $clog2(WAYS);
    // Row index width and row count
    localparam int HASH_WIDTH    = 8;
    localparam int INDEXES       = 1 << HASH_WIDTH;
    localparam int IP_ADDR_WIDTH = 32;
    // Connection id is {way, hash}
    localparam int CONN_ID_WIDTH = HASH_WIDTH + WAYS_LOG;
    // Read latency of every RAM port
    localparam int BRAM_LATENCY  = 2;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [IP_ADDR_WIDTH-1:0] ip_addr_t;
    typedef logic [HASH_WIDTH-1:0]    hash_t;
    typedef logic [WAYS_LOG-1:0]      way_t;
    typedef logic [CONN_ID_WIDTH-1:0] conn_id_t;
    // One bit per way
    typedef logic [WAYS-1:0]          way_mask_t;

    // Control FSM states
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_READ_WAIT,
        CTRL_BIND_CHECK,
        CTRL_BIND_SCAN,
        CTRL_UNBIND
    } ctrl_state_t;

    // Fold the four address bytes into one row index
    function automatic hash_t hash_ip(input ip_addr_t ip);
        return ip[31:24] ^ ip[23:16] ^ ip[15:8] ^ ip[7:0];
    endfunction

endpackage

// File: hdl/way_table_if.sv
interface way_table_if
    import conn_pkg::*;
();

    // ----------------------------------------
    // Engine to table
    // ----------------------------------------

    // Row address, shared by read and write
    hash_t     addr;
    // Per-way write strobes, applied at the next edge
    way_mask_t wr_en;
    ip_addr_t  wr_tag;
    // Valid bit written along with the tag
    logic      wr_valid;

    // ----------------------------------------
    // Table to engine
    // ----------------------------------------

    // Row contents for addr, BRAM_LATENCY cycles late
    ip_addr_t [WAYS-1:0] rd_tag;
    way_mask_t           rd_valid;

    modport engine (
        output addr, wr_en, wr_tag, wr_valid,
        input  rd_tag, rd_valid
    );

    modport tbl (
        input  addr, wr_en, wr_tag, wr_valid,
        output rd_tag, rd_valid
    );

endinterface

// File: hdl/tag_ram.sv
module tag_ram
    import conn_pkg::*;
#(
    parameter int DEPTH = INDEXES,
    parameter int WIDTH = IP_ADDR_WIDTH
)(
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] a_addr,
    input  logic [WIDTH-1:0]         a_din,
    output logic [WIDTH-1:0]         a_dout,
    input  logic [$clog2(DEPTH)-1:0] b_addr,
    output logic [WIDTH-1:0]         b_dout
);

    // Storage, no reset
    logic [WIDTH-1:0] mem    [DEPTH];
    // Output register chains, one per read port
    logic [WIDTH-1:0] a_pipe [BRAM_LATENCY];
    logic [WIDTH-1:0] b_pipe [BRAM_LATENCY];

    always_ff @(posedge clk) begin
        // Port A writes
        if (wr_en) begin
            mem[a_addr] <= a_din;
        end
        // Both ports read old data on a same-address write
        a_pipe[0] <= mem[a_addr];
        b_pipe[0] <= mem[b_addr];
        for (int i = 1; i < BRAM_LATENCY; i++) begin
            a_pipe[i] <= a_pipe[i-1];
            b_pipe[i] <= b_pipe[i-1];
        end
    end

    // Last stage of each chain
    assign a_dout = a_pipe[BRAM_LATENCY-1];
    assign b_dout = b_pipe[BRAM_LATENCY-1];

endmodule

// File: hdl/way_table.sv
module way_table
    import conn_pkg::*;
(
    input  logic                s00_axis_fw_lookup_aclk,
    input  logic                arst_n,
    way_table_if.tbl            ctrl,
    input  hash_t               fw_addr,
    output ip_addr_t [WAYS-1:0] fw_tag,
    output way_mask_t           fw_valid
);

    // ----------------------------------------
    // Tag storage
    // ----------------------------------------

    // One RAM per way
    // Port A belongs to the control engine, port B to the lookup
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        tag_ram #(
            .DEPTH (INDEXES),
            .WIDTH (IP_ADDR_WIDTH)
        ) u_tag_ram (
            .clk    (s00_axis_fw_lookup_aclk),
            .wr_en  (ctrl.wr_en[w]),
            .a_addr (ctrl.addr),
            .a_din  (ctrl.wr_tag),
            .a_dout (ctrl.rd_tag[w]),
            .b_addr (fw_addr),
            .b_dout (fw_tag[w])
        );
    end

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------

    // Flops so that the table is empty after reset
    way_mask_t valid_bits [INDEXES];
    // Delay chains matching the tag RAM latency
    way_mask_t ctrl_vpipe [BRAM_LATENCY];
    way_mask_t fw_vpipe   [BRAM_LATENCY];

    always_ff @(posedge s00_axis_fw_lookup_aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < INDEXES; i++) begin
                valid_bits[i] <= '0;
            end
            for (int i = 0; i < BRAM_LATENCY; i++) begin
                ctrl_vpipe[i] <= '0;
                fw_vpipe[i]   <= '0;
            end
        end else begin
            // Only the strobed ways of the row change
            for (int w = 0; w < WAYS; w++) begin
                if (ctrl.wr_en[w]) begin
                    valid_bits[ctrl.addr][w] <= ctrl.wr_valid;
                end
            end
            // Read old row, same as the tag RAMs
            ctrl_vpipe[0] <= valid_bits[ctrl.addr];
            fw_vpipe[0]   <= valid_bits[fw_addr];
            for (int i = 1; i < BRAM_LATENCY; i++) begin
                ctrl_vpipe[i] <= ctrl_vpipe[i-1];
                fw_vpipe[i]   <= fw_vpipe[i-1];
            end
        end
    end

    assign ctrl.rd_valid = ctrl_vpipe[BRAM_LATENCY-1];
    assign fw_valid      = fw_vpipe[BRAM_LATENCY-1];

endmodule

// File: hdl/fw_lookup.sv
module fw_lookup
    import conn_pkg::*;
(
    input  logic                s00_axis_fw_lookup_aclk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  ip_addr_t            req_ip,
    output hash_t               fw_addr,
    input  ip_addr_t [WAYS-1:0] fw_tag,
    input  way_mask_t           fw_valid,
    output logic                rsp_valid,
    output logic                rsp_hit,
    output conn_id_t            rsp_conn_id
);

    // Request fields travelling alongside the RAM read
    ip_addr_t                ip_pipe   [BRAM_LATENCY];
    hash_t                   hash_pipe [BRAM_LATENCY];
    logic [BRAM_LATENCY-1:0] valid_pipe;

    // ----------------------------------------
    // Hash stage
    // ----------------------------------------

    // Row index goes straight to the table read port
    assign fw_addr = hash_ip(req_ip);

    // Strobe chain
    always_ff @(posedge s00_axis_fw_lookup_aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= req_valid;
            for (int i = 1; i < BRAM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // Address and hash chain
    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        ip_pipe[0]   <= req_ip;
        hash_pipe[0] <= fw_addr;
        for (int i = 1; i < BRAM_LATENCY; i++) begin
            ip_pipe[i]   <= ip_pipe[i-1];
            hash_pipe[i] <= hash_pipe[i-1];
        end
    end

    // ----------------------------------------
    // Compare and encode
    // ----------------------------------------

    // Walk ways downwards so the lowest matching way wins
    always_comb begin
        rsp_hit     = 1'b0;
        rsp_conn_id = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (fw_valid[w] && fw_tag[w] == ip_pipe[BRAM_LATENCY-1]) begin
                rsp_hit     = 1'b1;
                rsp_conn_id = {way_t'(w), hash_pipe[BRAM_LATENCY-1]};
            end
        end
    end

    assign rsp_valid = valid_pipe[BRAM_LATENCY-1];

endmodule

// File: hdl/bind_engine.sv
module bind_engine
    import conn_pkg::*;
(
    input  logic        s00_axis_fw_lookup_aclk,
    input  logic        arst_n,
    input  logic        cmd_valid,
    input  ip_addr_t    cmd_ip,
    input  logic        cmd_bind,
    output logic        cmd_ready,
    way_table_if.engine tbl,
    output logic        rsp_valid,
    output logic        rsp_ack,
    output logic        rsp_full,
    output conn_id_t    rsp_conn_id
);

    ctrl_state_t state, state_d;
    // Latched command
    ip_addr_t    cmd_ip_q;
    hash_t       hash_q;
    logic        bind_q;
    // Read wait counter and way scan pointer
    logic [$clog2(BRAM_LATENCY+1)-1:0] wait_cnt, wait_d;
    way_t        way_iter, iter_d;
    // Next response and write strobes
    logic        valid_d, ack_d, full_d;
    conn_id_t    id_d;
    way_mask_t   wr_en_d, wr_en_q;
    // Row decode
    way_mask_t   tag_match;
    logic        hit_any;
    way_t        hit_way;
    logic        accept;

    // Hold off a new command during the response pulse
    assign cmd_ready = (state == CTRL_IDLE) && !rsp_valid;
    assign accept    = cmd_valid && cmd_ready;

    // Table port
    assign tbl.addr     = hash_q;
    assign tbl.wr_tag   = cmd_ip_q;
    assign tbl.wr_valid = bind_q;
    assign tbl.wr_en    = wr_en_q;

    // ----------------------------------------
    // Row decode
    // ----------------------------------------

    // Lowest valid way holding the address
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            tag_match[w] = (tbl.rd_tag[w] == cmd_ip_q);
            if (tag_match[w] && tbl.rd_valid[w]) begin
                hit_any = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // ----------------------------------------
    // FSM next state
    // ----------------------------------------

    always_comb begin
        state_d = state;
        wait_d  = wait_cnt;
        iter_d  = way_iter;
        valid_d = 1'b0;
        ack_d   = 1'b0;
        full_d  = 1'b0;
        id_d    = '0;
        wr_en_d = '0;
        case (state)
            CTRL_IDLE: begin
                wait_d = '0;
                iter_d = '0;
                if (accept) begin
                    state_d = CTRL_READ_WAIT;
                end
            end
            // Row arrives BRAM_LATENCY cycles after hash_q settles
            CTRL_READ_WAIT: begin
                wait_d = wait_cnt + 1'b1;
                if (wait_cnt == BRAM_LATENCY - 1) begin
                    state_d = bind_q ? CTRL_BIND_CHECK : CTRL_UNBIND;
                end
            end
            // Already bound, report the existing id
            CTRL_BIND_CHECK: begin
                if (hit_any) begin
                    valid_d = 1'b1;
                    ack_d   = 1'b1;
                    id_d    = {hit_way, hash_q};
                    state_d = CTRL_IDLE;
                end else begin
                    state_d = CTRL_BIND_SCAN;
                end
            end
            // One way per cycle, first free way gets the tag
            CTRL_BIND_SCAN: begin
                if (!tbl.rd_valid[way_iter]) begin
                    wr_en_d[way_iter] = 1'b1;
                    valid_d           = 1'b1;
                    ack_d             = 1'b1;
                    id_d              = {way_iter, hash_q};
                    state_d           = CTRL_IDLE;
                end else if (way_iter == way_t'(WAYS - 1)) begin
                    // Row full
                    valid_d = 1'b1;
                    full_d  = 1'b1;
                    state_d = CTRL_IDLE;
                end else begin
                    iter_d = way_iter + 1'b1;
                end
            end
            // Clear every way holding the address
            CTRL_UNBIND: begin
                wr_en_d = tag_match;
                valid_d = 1'b1;
                ack_d   = 1'b1;
                state_d = CTRL_IDLE;
            end
            default: state_d = CTRL_IDLE;
        endcase
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    always_ff @(posedge s00_axis_fw_lookup_aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= CTRL_IDLE;
            wait_cnt  <= '0;
            way_iter  <= '0;
            wr_en_q   <= '0;
            rsp_valid <= 1'b0;
            rsp_ack   <= 1'b0;
            rsp_full  <= 1'b0;
        end else begin
            state     <= state_d;
            wait_cnt  <= wait_d;
            way_iter  <= iter_d;
            // Write lands one edge after the response pulse starts
            wr_en_q   <= wr_en_d;
            rsp_valid <= valid_d;
            rsp_ack   <= ack_d;
            rsp_full  <= full_d;
        end
    end

    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        if (accept) begin
            cmd_ip_q <= cmd_ip;
            hash_q   <= hash_ip(cmd_ip);
            bind_q   <= cmd_bind;
        end
        rsp_conn_id <= id_d;
    end

endmodule

// File: hdl/conn_manager_top.sv
module conn_manager_top
    import conn_pkg::*;
(
    input  logic     s00_axis_fw_lookup_aclk,
    input  logic     arst_n,
    // Forward lookup request
    input  logic     s00_axis_fw_lookup_valid,
    input  ip_addr_t s00_axis_fw_lookup_ip_addr,
    output logic     s00_axis_fw_lookup_ready,
    // Forward lookup result
    output logic     m00_axis_fw_lookup_valid,
    output logic     m00_axis_fw_lookup_hit,
    output conn_id_t m00_axis_fw_lookup_connection_id,
    // Bind and unbind commands
    input  logic     s02_axis_ctrl_valid,
    input  ip_addr_t s02_axis_ctrl_ip_addr,
    input  logic     s02_axis_ctrl_bind,
    output logic     s02_axis_ctrl_ready,
    // Command response
    output logic     m02_axis_ctrl_valid,
    output logic     m02_axis_ctrl_ack,
    output logic     m02_axis_ctrl_full,
    output conn_id_t m02_axis_ctrl_connection_id
);

    // Forward read port
    hash_t               fw_addr;
    ip_addr_t [WAYS-1:0] fw_tag;
    way_mask_t           fw_valid;

    // Control read/write port
    way_table_if tbl_if ();

    // Lookup pipeline never stalls
    assign s00_axis_fw_lookup_ready = 1'b1;

    way_table u_way_table (
        .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
        .arst_n                  (arst_n),
        .ctrl                    (tbl_if.tbl),
        .fw_addr                 (fw_addr),
        .fw_tag                  (fw_tag),
        .fw_valid                (fw_valid)
    );

    fw_lookup u_fw_lookup (
        .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
        .arst_n                  (arst_n),
        .req_valid               (s00_axis_fw_lookup_valid),
        .req_ip                  (s00_axis_fw_lookup_ip_addr),
        .fw_addr                 (fw_addr),
        .fw_tag                  (fw_tag),
        .fw_valid                (fw_valid),
        .rsp_valid               (m00_axis_fw_lookup_valid),
        .rsp_hit                 (m00_axis_fw_lookup_hit),
        .rsp_conn_id             (m00_axis_fw_lookup_connection_id)
    );

    bind_engine u_bind_engine (
        .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
        .arst_n                  (arst_n),
        .cmd_valid               (s02_axis_ctrl_valid),
        .cmd_ip                  (s02_axis_ctrl_ip_addr),
        .cmd_bind                (s02_axis_ctrl_bind),
        .cmd_ready               (s02_axis_ctrl_ready),
        .tbl                     (tbl_if.engine),
        .rsp_valid               (m02_axis_ctrl_valid),
        .rsp_ack                 (m02_axis_ctrl_ack),
        .rsp_full                (m02_axis_ctrl_full),
        .rsp_conn_id             (m02_axis_ctrl_connection_id)
    );

endmodule

// File: verification/tb_conn_manager.sv
module tb_conn_manager
    import conn_pkg::*;
();

    // ----------------------------------------
    // Timing limits
    // ----------------------------------------

    localparam int CLK_PERIOD  = 4;
    // Longest bind plus slack, in cycles
    localparam int CTRL_WAIT   = BRAM_LATENCY + WAYS + 4;
    localparam int NUM_OPS     = 64;
    localparam int WATCHDOG_T  = NUM_OPS * CTRL_WAIT * CLK_PERIOD * 2;

    logic      s00_axis_fw_lookup_aclk;
    logic      arst_n;
    // Lookup side
    logic      fw_req_valid;
    ip_addr_t  fw_req_ip;
    logic      fw_ready;
    logic      fw_rsp_valid;
    logic      fw_rsp_hit;
    conn_id_t  fw_rsp_id;
    // Control side
    logic      ctrl_valid;
    ip_addr_t  ctrl_ip;
    logic      ctrl_bind;
    logic      ctrl_ready;
    logic      ctrl_rsp_valid;
    logic      ctrl_rsp_ack;
    logic      ctrl_rsp_full;
    conn_id_t  ctrl_rsp_id;

    int        errors = 0;
    int        lookups_done = 0;
    int        cmds_done = 0;
    // Posedges since time zero
    int        cyc = 0;
    logic [31:0] rng_state = 32'hd5b4;

    // Reference model: address to id, plus occupied ways per row
    conn_id_t  model_id [ip_addr_t];
    way_mask_t occ [INDEXES];
    ip_addr_t  known_q [$];
    // Outstanding lookups, oldest first
    int        due_q [$];
    logic      exp_hit_q [$];
    conn_id_t  exp_id_q [$];

    conn_manager_top UUT (
        .s00_axis_fw_lookup_aclk          (s00_axis_fw_lookup_aclk),
        .arst_n                           (arst_n),
        .s00_axis_fw_lookup_valid         (fw_req_valid),
        .s00_axis_fw_lookup_ip_addr       (fw_req_ip),
        .s00_axis_fw_lookup_ready         (fw_ready),
        .m00_axis_fw_lookup_valid         (fw_rsp_valid),
        .m00_axis_fw_lookup_hit           (fw_rsp_hit),
        .m00_axis_fw_lookup_connection_id (fw_rsp_id),
        .s02_axis_ctrl_valid              (ctrl_valid),
        .s02_axis_ctrl_ip_addr            (ctrl_ip),
        .s02_axis_ctrl_bind               (ctrl_bind),
        .s02_axis_ctrl_ready              (ctrl_ready),
        .m02_axis_ctrl_valid              (ctrl_rsp_valid),
        .m02_axis_ctrl_ack                (ctrl_rsp_ack),
        .m02_axis_ctrl_full               (ctrl_rsp_full),
        .m02_axis_ctrl_connection_id      (ctrl_rsp_id)
    );

    initial begin
        s00_axis_fw_lookup_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) s00_axis_fw_lookup_aclk = ~s00_axis_fw_lookup_aclk;
    end

    always @(posedge s00_axis_fw_lookup_aclk) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Same bit flipped in bytes 3 and 2, so the XOR fold is unchanged
    function automatic ip_addr_t collide(input ip_addr_t base, input int k);
        return base ^ (32'h0101_0000 << k);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    endtask

    // Lookup result checker, one result per negedge at most
    always @(negedge s00_axis_fw_lookup_aclk) begin
        if (arst_n) begin
            if (fw_rsp_valid) begin
                if (due_q.size() == 0) begin
                    errors++;
                    $display("Unexpected lookup result at time %0t", $time);
                end else begin
                    if (cyc != due_q[0])
                        report_mismatch("m00 arrival cycle", due_q[0], cyc);
                    if (fw_rsp_hit !== exp_hit_q[0])
                        report_mismatch("m00_axis_fw_lookup_hit", exp_hit_q[0], fw_rsp_hit);
                    if (fw_rsp_id !== exp_id_q[0])
                        report_mismatch("m00_axis_fw_lookup_connection_id", exp_id_q[0],
                                        fw_rsp_id);
                    void'(due_q.pop_front());
                    void'(exp_hit_q.pop_front());
                    void'(exp_id_q.pop_front());
                    lookups_done++;
                end
            end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
                errors++;
                $display("Lookup result missing at time %0t", $time);
                void'(due_q.pop_front());
                void'(exp_hit_q.pop_front());
                void'(exp_id_q.pop_front());
            end
        end
    end

    // ----------------------------------------
    // Lookup tasks
    // ----------------------------------------

    // Present one request and queue the model's answer
    task automatic issue_lookup(input ip_addr_t ip);
        @(posedge s00_axis_fw_lookup_aclk);
        fw_req_valid <= 1'b1;
        fw_req_ip    <= ip;
        due_q.push_back(cyc + 1 + BRAM_LATENCY);
        exp_hit_q.push_back(model_id.exists(ip));
        exp_id_q.push_back(model_id.exists(ip) ? model_id[ip] : conn_id_t'(0));
    endtask

    // Stop requesting and wait for every result
    task automatic drain_lookups();
        int n;
        n = 0;
        @(posedge s00_axis_fw_lookup_aclk);
        fw_req_valid <= 1'b0;
        while (due_q.size() > 0 && n < CTRL_WAIT) begin
            @(negedge s00_axis_fw_lookup_aclk);
            n++;
        end
        if (due_q.size() > 0) begin
            errors++;
            $display("Lookup results still pending at time %0t", $time);
        end
    endtask

    task automatic lookup_check(input ip_addr_t ip);
        issue_lookup(ip);
        drain_lookups();
    endtask

    // ----------------------------------------
    // Control tasks
    // ----------------------------------------

    task automatic run_ctrl(input ip_addr_t ip, input logic is_bind, input logic exp_ack,
                            input logic exp_full, input conn_id_t exp_id,
                            input logic check_id);
        int n;
        n = 0;
        @(negedge s00_axis_fw_lookup_aclk);
        while (!ctrl_ready && n < CTRL_WAIT) begin
            @(negedge s00_axis_fw_lookup_aclk);
            n++;
        end
        if (!ctrl_ready) begin
            errors++;
            $display("Control port never became ready for %h", ip);
            return;
        end
        @(posedge s00_axis_fw_lookup_aclk);
        ctrl_valid <= 1'b1;
        ctrl_ip    <= ip;
        ctrl_bind  <= is_bind;
        @(posedge s00_axis_fw_lookup_aclk);
        ctrl_valid <= 1'b0;
        n = 0;
        @(negedge s00_axis_fw_lookup_aclk);
        while (!ctrl_rsp_valid && n < CTRL_WAIT) begin
            if (ctrl_ready)
                report_mismatch("s02_axis_ctrl_ready", 0, ctrl_ready);
            @(negedge s00_axis_fw_lookup_aclk);
            n++;
        end
        if (!ctrl_rsp_valid) begin
            errors++;
            $display("No control response for address %h", ip);
            return;
        end
        if (ctrl_rsp_ack !== exp_ack)
            report_mismatch("m02_axis_ctrl_ack", exp_ack, ctrl_rsp_ack);
        if (ctrl_rsp_full !== exp_full)
            report_mismatch("m02_axis_ctrl_full", exp_full, ctrl_rsp_full);
        if (check_id && ctrl_rsp_id !== exp_id)
            report_mismatch("m02_axis_ctrl_connection_id", exp_id, ctrl_rsp_id);
        // Pulse lasts one cycle, ready comes back right after
        @(negedge s00_axis_fw_lookup_aclk);
        if (ctrl_rsp_valid !== 1'b0)
            report_mismatch("m02_axis_ctrl_valid", 0, ctrl_rsp_valid);
        if (ctrl_ready !== 1'b1)
            report_mismatch("s02_axis_ctrl_ready", 1, ctrl_ready);
        cmds_done++;
    endtask

    // Existing id, else lowest free way, else full
    task automatic bind_cmd(input ip_addr_t ip);
        hash_t    h;
        int       free_way;
        h = hash_ip(ip);
        free_way = -1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!occ[h][w])
                free_way = w;
        end
        if (model_id.exists(ip)) begin
            run_ctrl(ip, 1'b1, 1'b1, 1'b0, model_id[ip], 1'b1);
        end else if (free_way >= 0) begin
            occ[h][free_way] = 1'b1;
            model_id[ip] = {way_t'(free_way), h};
            run_ctrl(ip, 1'b1, 1'b1, 1'b0, model_id[ip], 1'b1);
        end else begin
            run_ctrl(ip, 1'b1, 1'b0, 1'b1, '0, 1'b1);
        end
        known_q.push_back(ip);
    endtask

    task automatic unbind_cmd(input ip_addr_t ip);
        if (model_id.exists(ip)) begin
            occ[hash_ip(ip)][model_id[ip][CONN_ID_WIDTH-1:HASH_WIDTH]] = 1'b0;
            model_id.delete(ip);
        end
        run_ctrl(ip, 1'b0, 1'b1, 1'b0, '0, 1'b0);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic reset_state_test();
        @(negedge s00_axis_fw_lookup_aclk);
        if (fw_ready !== 1'b1)
            report_mismatch("s00_axis_fw_lookup_ready", 1, fw_ready);
        if (ctrl_ready !== 1'b1)
            report_mismatch("s02_axis_ctrl_ready", 1, ctrl_ready);
        if (fw_rsp_valid !== 1'b0)
            report_mismatch("m00_axis_fw_lookup_valid", 0, fw_rsp_valid);
        if (ctrl_rsp_valid !== 1'b0)
            report_mismatch("m02_axis_ctrl_valid", 0, ctrl_rsp_valid);
        if (ctrl_rsp_ack !== 1'b0 || ctrl_rsp_full !== 1'b0)
            report_mismatch("m02 ack/full", 0, {ctrl_rsp_ack, ctrl_rsp_full});
        // Empty table misses
        lookup_check(next_rand());
    endtask

    task automatic rebind_test(input ip_addr_t a);
        bind_cmd(a);
        // Same id again, no way consumed, so the collider lands in way 1
        bind_cmd(collide(a, 0));
        lookup_check(collide(a, 0));
    endtask

    task automatic back_to_back_test(input int count);
        for (int i = 0; i < count; i++) begin
            if (i % 2 == 0)
                issue_lookup(known_q[(i / 2) % known_q.size()]);
            else
                issue_lookup(next_rand());
        end
        drain_lookups();
    endtask

    initial begin
        ip_addr_t a;
        ip_addr_t b;
        a = 32'hc0a8_0001;
        b = 32'h0a00_0005;
        for (int i = 0; i < INDEXES; i++) begin
            occ[i] = '0;
        end
        arst_n       = 1'b0;
        fw_req_valid = 1'b0;
        fw_req_ip    = '0;
        ctrl_valid   = 1'b0;
        ctrl_ip      = '0;
        ctrl_bind    = 1'b0;
        repeat (2) @(posedge s00_axis_fw_lookup_aclk);
        arst_n <= 1'b1;

        reset_state_test();
        // New address takes way 0, a neighbour misses
        bind_cmd(a);
        lookup_check(a);
        lookup_check(a ^ 32'h1);
        rebind_test(a);
        // Fill one row, then overflow it
        for (int k = 0; k <= WAYS; k++) begin
            bind_cmd(collide(b, k));
        end
        for (int k = 0; k < WAYS; k++) begin
            lookup_check(collide(b, k));
        end
        // Free way 1 and reuse it
        unbind_cmd(collide(b, 1));
        lookup_check(collide(b, 1));
        bind_cmd(collide(b, 5));
        lookup_check(collide(b, 5));
        back_to_back_test(32);

        $display("Errors: %0d, lookups: %0d, commands: %0d", errors, lookups_done, cmds_done);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Run time limit
    initial begin
        #(WATCHDOG_T);
        $display("Watchdog expired at time %0t with %0d errors", $time, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: project.f
hdl/conn_pkg.sv
hdl/way_table_if.sv
hdl/tag_ram.sv
hdl/way_table.sv
hdl/fw_lookup.sv
hdl/bind_engine.sv
hdl/conn_manager_top.sv
verification/tb_conn_manager.sv
